// ==== cam_pkg.sv ====
package cam_pkg;

    // Pixel and memory word geometry.
    localparam int PIX_W        = 16;
    localparam int WORD_W       = 256;
    localparam int PIX_PER_WORD = 16;
    localparam int WORD_BYTES   = WORD_W / 8;

    // Kept small for simulation.
    localparam int FRAME_PIXELS = 512;

    localparam int BURST_LEN   = 4;
    localparam int BURST_BYTES = BURST_LEN * WORD_BYTES;
    localparam int ADDR_W      = 28;

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W    = PTR_W + 1;

    localparam int SLOT_W    = $clog2(PIX_PER_WORD);
    localparam int PIX_CNT_W = $clog2(FRAME_PIXELS + 1);

    localparam int BLINK_TICK = 375_000;
    localparam int BLINK_W    = $clog2(BLINK_TICK);

    // Burst writer FSM states.
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] data;
    } pix_beat_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } mem_word_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;
    } burst_cmd_t;

endpackage : cam_pkg

// ==== frame_sync.sv ====
module frame_sync import cam_pkg::*; (
    input  logic             cam1_pclk,
    input  logic             rstn,
    input  logic             trig,
    input  logic             cam1_vsync,
    input  logic             cam1_href,
    input  logic [PIX_W-1:0] cam1_data,
    input  logic             fifo_empty,
    output pix_beat_t        pix,
    output logic             frame_start
);

    logic                 pending;
    logic                 armed;
    logic                 frame_done;
    logic [PIX_CNT_W-1:0] pix_cnt;
    logic                 pix_valid;
    logic [PIX_W-1:0]     pix_data;

    assign frame_done = (pix_cnt == PIX_CNT_W'(FRAME_PIXELS));

    // Trig only takes effect at the next vsync.
    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            pending     <= 1'b0;
            armed       <= 1'b0;
            pix_cnt     <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (!armed) begin
                if (pending && cam1_vsync) begin
                    armed       <= 1'b1;
                    pending     <= 1'b0;
                    pix_cnt     <= '0;
                    frame_start <= 1'b1;
                end else if (trig) begin
                    pending <= 1'b1;
                end
            end else if (!frame_done) begin
                if (cam1_href) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else if (fifo_empty && !pix_valid) begin
                armed <= 1'b0;
            end
        end
    end

    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= armed && !frame_done && cam1_href;
        end
    end

    always_ff @(posedge cam1_pclk) begin
        if (cam1_href) begin
            pix_data <= cam1_data;
        end
    end

    assign pix = '{valid: pix_valid, data: pix_data};

endmodule : frame_sync

// ==== pixel_packer.sv ====
module pixel_packer import cam_pkg::*; (
    input  logic      cam1_pclk,
    input  logic      rstn,
    input  pix_beat_t pix,
    input  logic      frame_start,
    output mem_word_t word
);

    logic [SLOT_W-1:0] slot;
    logic              last_slot;
    logic              word_valid;
    logic [WORD_W-1:0] shreg;

    assign last_slot = (slot == SLOT_W'(PIX_PER_WORD - 1));

    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            slot       <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (frame_start) begin
                slot <= '0;
            end else if (pix.valid) begin
                word_valid <= last_slot;
                if (last_slot) begin
                    slot <= '0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    // New pixels enter at the top, so the first one ends up in the lowest bits.
    always_ff @(posedge cam1_pclk) begin
        if (pix.valid) begin
            shreg <= {pix.data, shreg[WORD_W-1:PIX_W]};
        end
    end

    // The shift register holds still while the word is valid.
    // No pixel can have been shifted in during that cycle yet.
    assign word = '{valid: word_valid, data: shreg};

endmodule : pixel_packer

// ==== word_fifo.sv ====
module word_fifo import cam_pkg::*; (
    input  logic               cam1_pclk,
    input  logic               rstn,
    input  mem_word_t          wr,
    input  logic               pop,
    output logic [WORD_W-1:0]  head,
    output logic [LEVEL_W-1:0] level,
    output logic               empty,
    output logic               overflow
);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              full;
    logic              push;
    logic              do_pop;

    assign full   = (level == LEVEL_W'(FIFO_DEPTH));
    assign empty  = (level == '0);
    assign do_pop = pop && !empty;

    // A pop in the same cycle makes room for the write.
    assign push     = wr.valid && (!full || do_pop);
    assign overflow = wr.valid && !push;

    assign head = mem[rd_ptr];

    // Depth is a power of two, so pointers wrap on their own.
    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge cam1_pclk) begin
        if (push) begin
            mem[wr_ptr] <= wr.data;
        end
    end

endmodule : word_fifo

// ==== burst_writer.sv ====
module burst_writer import cam_pkg::*; (
    input  logic               cam1_pclk,
    input  logic               rstn,
    input  logic               frame_start,
    input  logic [LEVEL_W-1:0] level,
    input  logic [WORD_W-1:0]  head,
    input  logic               axi_awready,
    input  logic               axi_wready,
    input  logic               axi_wusero_last,
    output logic               pop,
    output logic [ADDR_W-1:0]  axi_awaddr,
    output logic [3:0]         axi_awlen,
    output logic               axi_awvalid,
    output logic [WORD_W-1:0]  axi_wdata
);

    logic [1:0] state;
    logic       restart;
    burst_cmd_t cmd;

    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (level >= LEVEL_W'(BURST_LEN)) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (axi_awready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    // The memory flags the final beat of the burst.
                    if (axi_wready && axi_wusero_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // A new frame restarts the word index, but only between bursts
    // so that a pending command never changes under awvalid.
    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            restart <= 1'b0;
            cmd     <= '{addr: '0, len: 4'(BURST_LEN - 1)};
        end else begin
            if (frame_start) begin
                restart <= 1'b1;
            end
            if (state == ST_IDLE && (restart || frame_start)) begin
                restart  <= 1'b0;
                cmd.addr <= '0;
            end else if (state == ST_ADDR && axi_awready) begin
                cmd.addr <= cmd.addr + ADDR_W'(BURST_BYTES);
            end
        end
    end

    assign axi_awvalid = (state == ST_ADDR);
    assign axi_awaddr  = cmd.addr;
    assign axi_awlen   = cmd.len;

    // Beats leave the FIFO head whenever the memory is ready.
    assign pop       = (state == ST_DATA) && axi_wready;
    assign axi_wdata = head;

endmodule : burst_writer

// ==== error_blinker.sv ====
module error_blinker import cam_pkg::*; (
    input  logic cam1_pclk,
    input  logic rstn,
    input  logic overflow,
    output logic error
);

    logic               fault;
    logic [BLINK_W-1:0] tick;

    // Once set, only reset clears the fault.
    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            fault <= 1'b0;
            tick  <= '0;
            error <= 1'b0;
        end else if (!fault) begin
            if (overflow) begin
                fault <= 1'b1;
                error <= 1'b1;
                tick  <= '0;
            end
        end else if (tick == BLINK_W'(BLINK_TICK - 1)) begin
            tick  <= '0;
            error <= ~error;
        end else begin
            tick <= tick + 1'b1;
        end
    end

endmodule : error_blinker

// ==== ddr_writer.sv ====
module ddr_writer import cam_pkg::*; (
    input  logic              rstn,
    input  logic              trig,

    input  logic              cam1_pclk,
    input  logic              cam1_href,
    input  logic              cam1_vsync,
    input  logic [PIX_W-1:0]  cam1_data,

    output logic              error,

    // Write address channel.
    output logic [ADDR_W-1:0] axi_awaddr,
    output logic [3:0]        axi_awlen,
    input  logic              axi_awready,
    output logic              axi_awvalid,

    // Write data channel.
    output logic [WORD_W-1:0] axi_wdata,
    input  logic              axi_wready,
    input  logic              axi_wusero_last
);

    pix_beat_t          pix;
    mem_word_t          word;
    logic               frame_start;
    logic [WORD_W-1:0]  head;
    logic [LEVEL_W-1:0] level;
    logic               empty;
    logic               overflow;
    logic               pop;

    frame_sync u_frame_sync (
        .cam1_pclk  (cam1_pclk  ),
        .rstn       (rstn       ),
        .trig       (trig       ),
        .cam1_vsync (cam1_vsync ),
        .cam1_href  (cam1_href  ),
        .cam1_data  (cam1_data  ),
        .fifo_empty (empty      ),
        .pix        (pix        ),
        .frame_start(frame_start)
    );

    pixel_packer u_pixel_packer (
        .cam1_pclk  (cam1_pclk  ),
        .rstn       (rstn       ),
        .pix        (pix        ),
        .frame_start(frame_start),
        .word       (word       )
    );

    word_fifo u_word_fifo (
        .cam1_pclk(cam1_pclk),
        .rstn     (rstn     ),
        .wr       (word     ),
        .pop      (pop      ),
        .head     (head     ),
        .level    (level    ),
        .empty    (empty    ),
        .overflow (overflow )
    );

    burst_writer u_burst_writer (
        .cam1_pclk      (cam1_pclk      ),
        .rstn           (rstn           ),
        .frame_start    (frame_start    ),
        .level          (level          ),
        .head           (head           ),
        .axi_awready    (axi_awready    ),
        .axi_wready     (axi_wready     ),
        .axi_wusero_last(axi_wusero_last),
        .pop            (pop            ),
        .axi_awaddr     (axi_awaddr     ),
        .axi_awlen      (axi_awlen      ),
        .axi_awvalid    (axi_awvalid    ),
        .axi_wdata      (axi_wdata      )
    );

    error_blinker u_error_blinker (
        .cam1_pclk(cam1_pclk),
        .rstn     (rstn     ),
        .overflow (overflow ),
        .error    (error    )
    );

endmodule : ddr_writer

// ==== ddr_writer_sva.sv ====
module ddr_writer_sva import cam_pkg::*; (
    input logic              cam1_pclk,
    input logic              rstn,
    input logic              axi_awvalid,
    input logic              axi_awready,
    input logic [ADDR_W-1:0] axi_awaddr,
    input logic [3:0]        axi_awlen,
    input logic              error,
    input logic              overflow
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic seen_overflow;

    always_ff @(posedge cam1_pclk or negedge rstn) begin
        if (!rstn) begin
            seen_overflow <= 1'b0;
        end else if (overflow) begin
            seen_overflow <= 1'b1;
        end
    end

    awvalid_hold: assert property (@(posedge cam1_pclk) disable iff (!rstn)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
        else begin
            fail_count++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    awlen_fixed: assert property (@(posedge cam1_pclk) disable iff (!rstn)
        axi_awlen == 4'(BURST_LEN - 1))
        else begin
            fail_count++;
            $error("awlen differs from the burst length");
        end

    error_quiet: assert property (@(posedge cam1_pclk) disable iff (!rstn)
        !seen_overflow |-> !error)
        else begin
            fail_count++;
            $error("error is high although no overflow happened");
        end

endmodule : ddr_writer_sva

bind ddr_writer ddr_writer_sva sva0 (
    .cam1_pclk  (cam1_pclk  ),
    .rstn       (rstn       ),
    .axi_awvalid(axi_awvalid),
    .axi_awready(axi_awready),
    .axi_awaddr (axi_awaddr ),
    .axi_awlen  (axi_awlen  ),
    .error      (error      ),
    .overflow   (overflow   )
);

// ==== tb_ddr_writer.sv ====
module tb_ddr_writer import cam_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic       send_trig;
        logic       hold_ready;
        logic [7:0] ready_mask;
    } test_row_t;

    // Rows run in order, and the overflow row comes last since error is sticky.
    test_row_t rows [5] = '{
        '{1'b0, 1'b0, 8'hff},
        '{1'b1, 1'b0, 8'hff},
        '{1'b1, 1'b0, 8'b1011_0110},
        '{1'b1, 1'b0, 8'b0100_1001},
        '{1'b1, 1'b1, 8'hff}
    };
    string names [5] = '{
        "sync activity without trig",
        "full frame with wready high",
        "short wready stalls",
        "sparse wready on a new frame",
        "wready held low until overflow"
    };

    logic              cam1_pclk;
    logic              rstn;
    logic              trig;
    logic              cam1_vsync;
    logic              cam1_href;
    logic [PIX_W-1:0]  cam1_data;
    logic              error;
    logic [ADDR_W-1:0] axi_awaddr;
    logic [3:0]        axi_awlen;
    logic              axi_awready;
    logic              axi_awvalid;
    logic [WORD_W-1:0] axi_wdata;
    logic              axi_wready;
    logic              axi_wusero_last;

    logic [31:0]      lfsr = 32'h9396f4b8;
    logic [PIX_W-1:0] sb [$];
    logic [7:0]       ready_mask;
    logic             hold_ready;
    logic             in_data;
    int               beat_in_burst;
    int               cyc;
    int               bursts;
    int               beats;
    int               errors = 0;

    ddr_writer dut0 (.*);

    initial begin
        cam1_pclk = 1'b0;
        forever #10 cam1_pclk = ~cam1_pclk;
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic tick();
        @(posedge cam1_pclk);
        #2;
    endtask

    task automatic next_pixel(output logic [PIX_W-1:0] px);
        px = '0;
        for (int b = 0; b < PIX_W; b++) begin
            lfsr = lfsr_step(lfsr);
            px   = {px[PIX_W-2:0], lfsr[0]};
        end
    endtask

    // One vsync pulse, then lines of 32 pixels with short blanking.
    task automatic send_frame(input logic record);
        logic [PIX_W-1:0] px;
        cam1_vsync = 1'b1;
        repeat (2) tick();
        cam1_vsync = 1'b0;
        repeat (4) tick();
        for (int ln = 0; ln < FRAME_PIXELS / 32; ln++) begin
            for (int p = 0; p < 32; p++) begin
                next_pixel(px);
                cam1_href = 1'b1;
                cam1_data = px;
                if (record) begin
                    sb.push_back(px);
                end
                tick();
            end
            cam1_href = 1'b0;
            repeat (4) tick();
        end
    endtask

    task automatic check_word(input int idx, input logic [WORD_W-1:0] got);
        logic [WORD_W-1:0] exp;
        exp = '0;
        assert (idx * PIX_PER_WORD + PIX_PER_WORD <= sb.size()) begin
            for (int k = 0; k < PIX_PER_WORD; k++) begin
                exp[k*PIX_W +: PIX_W] = sb[idx * PIX_PER_WORD + k];
            end
            assert (got == exp) else begin
                $display("FAILED %0t axi_wdata beat %0d got %h expected %h",
                         $time, idx, got, exp);
                errors++;
            end
        end else begin
            $display("Data beat %0d arrived with no recorded pixels left for it", idx);
            errors++;
        end
    endtask

    // Waits until the DUT has been idle on both AXI channels for a while.
    task automatic wait_quiet(output bit ok);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        ok     = 1'b1;
        while (quiet < 64 && ok) begin
            @(posedge cam1_pclk);
            #1;
            cycles++;
            if (axi_awvalid || in_data) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (cycles > 5000) begin
                ok = 1'b0;
            end
        end
    endtask

    // The memory raises awready one cycle after awvalid and takes wready from the row mask.
    initial begin : memory_model
        logic hs;
        logic beat;
        logic awready_next;
        logic rdy;
        axi_awready     = 1'b0;
        axi_wready      = 1'b0;
        axi_wusero_last = 1'b0;
        in_data         = 1'b0;
        beat_in_burst   = 0;
        cyc             = 0;
        forever begin
            @(negedge cam1_pclk);
            hs   = axi_awvalid && axi_awready;
            beat = in_data && axi_wready;
            if (beat) begin
                check_word(beats, axi_wdata);
                beats++;
                if (axi_wusero_last) begin
                    in_data       = 1'b0;
                    beat_in_burst = 0;
                end else begin
                    beat_in_burst++;
                end
            end
            if (hs) begin
                assert (axi_awaddr == ADDR_W'(bursts * BURST_LEN * WORD_W / 8)) else begin
                    $display("FAILED %0t axi_awaddr got %0d expected %0d", $time,
                             axi_awaddr, bursts * BURST_LEN * WORD_W / 8);
                    errors++;
                end
                bursts++;
                in_data = 1'b1;
            end
            awready_next = axi_awvalid && !hs;
            @(posedge cam1_pclk);
            #2;
            rdy = hold_ready ? 1'b0 : ready_mask[cyc % 8];
            cyc++;
            axi_awready     = awready_next;
            axi_wready      = rdy;
            axi_wusero_last = in_data && rdy && (beat_in_burst == BURST_LEN - 1);
        end
    end

    initial begin : main
        test_row_t row;
        int        start_errs;
        int        failed_tests;
        bit        ok;
        failed_tests = 0;
        rstn         = 1'b0;
        trig         = 1'b0;
        cam1_vsync   = 1'b0;
        cam1_href    = 1'b0;
        cam1_data    = '0;
        hold_ready   = 1'b0;
        ready_mask   = 8'hff;
        bursts       = 0;
        beats        = 0;
        repeat (5) @(posedge cam1_pclk);
        #2;
        rstn = 1'b1;
        repeat (4) tick();

        for (int i = 0; i < 5; i++) begin
            row        = rows[i];
            start_errs = errors;
            sb.delete();
            bursts     = 0;
            beats      = 0;
            ready_mask = row.ready_mask;
            hold_ready = row.hold_ready;
            if (row.send_trig) begin
                trig = 1'b1;
                tick();
                trig = 1'b0;
            end
            send_frame(row.send_trig);
            hold_ready = 1'b0;
            wait_quiet(ok);
            if (!ok) begin
                $display("Timeout in test %0d, the DUT kept the AXI channels busy", i);
                errors++;
                break;
            end
            if (!row.send_trig) begin
                assert (bursts == 0) else begin
                    $display("FAILED %0t axi_awvalid handshakes got %0d expected 0",
                             $time, bursts);
                    errors++;
                end
            end else if (!row.hold_ready) begin
                assert (beats == FRAME_PIXELS / PIX_PER_WORD) else begin
                    $display("FAILED %0t data beats got %0d expected %0d", $time,
                             beats, FRAME_PIXELS / PIX_PER_WORD);
                    errors++;
                end
                assert (error == 1'b0) else begin
                    $display("FAILED %0t error got %b expected 0", $time, error);
                    errors++;
                end
            end else begin
                assert (beats > 0 && beats < FRAME_PIXELS / PIX_PER_WORD) else begin
                    $display("Overflow test delivered %0d words instead of part of a frame",
                             beats);
                    errors++;
                end
                assert (error == 1'b1) else begin
                    $display("FAILED %0t error got %b expected 1", $time, error);
                    errors++;
                end
            end
            if (errors != start_errs) begin
                failed_tests++;
            end
            $display("Test %0d (%s): %0d bursts, %0d words, %0d errors",
                     i, names[i], bursts, beats, errors - start_errs);
        end

        errors += dut0.sva0.fail_count;
        $display("Tests run 5, tests failed %0d, errors %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_ddr_writer

// ==== src.f ====
cam_pkg.sv
frame_sync.sv
pixel_packer.sv
word_fifo.sv
burst_writer.sv
error_blinker.sv
ddr_writer.sv
ddr_writer_sva.sv
tb_ddr_writer.sv

// ==== Bender.yml ====
package:
  name: ddr_writer

sources:
  - cam_pkg.sv
  - frame_sync.sv
  - pixel_packer.sv
  - word_fifo.sv
  - burst_writer.sv
  - error_blinker.sv
  - ddr_writer.sv
  - target: test
    files:
      - ddr_writer_sva.sv
      - tb_ddr_writer.sv
